// ==== compile.f ====
eeprom_pkg.sv
i2c_bit_engine.sv
eeprom_sequencer.sv
wb_eeprom_regs.sv
eeprom_ctrl_top.sv
tb_eeprom_model.sv
tb_eeprom_ctrl.sv

// ==== eeprom_ctrl_top.sv ====
`timescale 1ns/1ps
module eeprom_ctrl_top #(
    parameter int CLK_DIV = 4
) (
    input  logic       CLK,
    input  logic       RESET,
    input  logic [1:0] wb_adr,
    input  logic [7:0] wb_dat_i,
    output logic [7:0] wb_dat_o,
    input  logic       wb_we,
    input  logic       wb_stb,
    input  logic       wb_cyc,
    output logic       wb_ack,
    output logic       scl,
    output logic       sda_drive_low,
    input  logic       sda_in
);
    import eeprom_pkg::*;

    eeprom_req_t req;
    logic        req_valid;
    logic        busy;
    logic        done;
    eeprom_rsp_t seq_rsp;
    i2c_cmd_t    cmd;
    logic        cmd_valid;
    logic        cmd_done;
    i2c_rsp_t    bus_rsp;

    wb_eeprom_regs i_regs (
        .CLK(CLK), .RESET(RESET),
        .wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .wb_we(wb_we), .wb_stb(wb_stb),
        .wb_cyc(wb_cyc), .busy(busy), .done(done), .rsp(seq_rsp),
        .wb_dat_o(wb_dat_o), .wb_ack(wb_ack), .req(req), .req_valid(req_valid)
    );

    eeprom_sequencer i_seq (
        .CLK(CLK), .RESET(RESET), .req(req), .req_valid(req_valid),
        .cmd_done(cmd_done), .bus_rsp(bus_rsp), .busy(busy), .done(done),
        .rsp(seq_rsp), .cmd(cmd), .cmd_valid(cmd_valid)
    );

    i2c_bit_engine #(.CLK_DIV(CLK_DIV)) i_bit (
        .CLK(CLK), .RESET(RESET), .cmd(cmd), .cmd_valid(cmd_valid), .sda_in(sda_in),
        .cmd_done(cmd_done), .rsp(bus_rsp), .scl(scl), .sda_drive_low(sda_drive_low)
    );

endmodule

// ==== eeprom_pkg.sv ====
package eeprom_pkg;

    // 24C16 style byte address, bits 10:8 ride in the control byte
    localparam int ADDR_W = 11;

    localparam logic [3:0] DEV_TYPE = 4'b1010;

    typedef struct packed {
        logic              wr;     // 1 write, 0 read
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;
    } eeprom_req_t;

    typedef struct packed {
        logic [7:0] rdata;
        logic       nack;
    } eeprom_rsp_t;

    // start while the bus is held gives a repeated start
    typedef enum logic [1:0] {
        OP_START = 2'd0,
        OP_STOP  = 2'd1,
        OP_WRITE = 2'd2,
        OP_READ  = 2'd3
    } i2c_op_e;

    typedef struct packed {
        i2c_op_e    op;
        logic [7:0] data;
        logic       ack;    // level sent after a read byte
    } i2c_cmd_t;

    typedef struct packed {
        logic [7:0] data;
        logic       ack;    // sampled level, high means no ack
    } i2c_rsp_t;

    localparam logic [1:0] REG_ADDR_LO = 2'd0;
    localparam logic [1:0] REG_ADDR_HI = 2'd1;
    localparam logic [1:0] REG_DATA    = 2'd2;
    localparam logic [1:0] REG_CTRL    = 2'd3;

    localparam int CTRL_START_WR = 0;
    localparam int CTRL_START_RD = 1;
    localparam int CTRL_BUSY     = 0;
    localparam int CTRL_DONE     = 1;
    localparam int CTRL_NACK     = 2;

endpackage

// ==== eeprom_sequencer.sv ====
`timescale 1ns/1ps
module eeprom_sequencer (
    input  logic                    CLK,
    input  logic                    RESET,
    input  eeprom_pkg::eeprom_req_t req,
    input  logic                    req_valid,
    input  logic                    cmd_done,
    input  eeprom_pkg::i2c_rsp_t    bus_rsp,
    output logic                    busy,
    output logic                    done,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output eeprom_pkg::i2c_cmd_t    cmd,
    output logic                    cmd_valid
);
    import eeprom_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA,
        S_RSTART,
        S_CTRL_R,
        S_READ,
        S_STOP
    } state_e;

    state_e      state;
    state_e      state_nxt;
    eeprom_req_t req_q;
    i2c_cmd_t    cmd_nxt;
    logic        issue;
    logic        fin;
    logic        nack_set;
    logic        rd_cap;
    logic        nack_q;
    logic [7:0]  rdata_q;
    logic [7:0]  ctrl_w;
    logic [7:0]  ctrl_r;

    function automatic i2c_cmd_t mk_cmd(i2c_op_e op, logic [7:0] data, logic ack);
        i2c_cmd_t c;
        c.op   = op;
        c.data = data;
        c.ack  = ack;
        return c;
    endfunction

    // control byte from device type, block bits and r/w
    assign ctrl_w = {DEV_TYPE, req_q.addr[ADDR_W-1:8], 1'b0};
    assign ctrl_r = {DEV_TYPE, req_q.addr[ADDR_W-1:8], 1'b1};

    assign busy = (state != S_IDLE);
    assign rsp  = '{rdata: rdata_q, nack: nack_q};

    always_comb
    begin
        state_nxt = state;
        cmd_nxt   = cmd;
        issue     = 1'b0;
        fin       = 1'b0;
        nack_set  = 1'b0;
        rd_cap    = 1'b0;
        case (state)
            S_IDLE:
                if (req_valid)
                begin
                    state_nxt = S_START;
                    cmd_nxt   = mk_cmd(OP_START, 8'h00, 1'b1);
                    issue     = 1'b1;
                end
            S_STOP:
                if (cmd_done)
                begin
                    state_nxt = S_IDLE;
                    fin       = 1'b1;
                end
            default:
                if (cmd_done)
                begin
                    issue = 1'b1;
                    // a written byte without ack goes straight to stop
                    if ((state == S_CTRL_W || state == S_ADDR || state == S_DATA ||
                         state == S_CTRL_R) && bus_rsp.ack)
                    begin
                        nack_set  = 1'b1;
                        state_nxt = S_STOP;
                        cmd_nxt   = mk_cmd(OP_STOP, 8'h00, 1'b1);
                    end
                    else
                    begin
                        case (state)
                            S_START:
                            begin
                                state_nxt = S_CTRL_W;
                                cmd_nxt   = mk_cmd(OP_WRITE, ctrl_w, 1'b1);
                            end
                            S_CTRL_W:
                            begin
                                state_nxt = S_ADDR;
                                cmd_nxt   = mk_cmd(OP_WRITE, req_q.addr[7:0], 1'b1);
                            end
                            S_ADDR:
                                if (req_q.wr)
                                begin
                                    state_nxt = S_DATA;
                                    cmd_nxt   = mk_cmd(OP_WRITE, req_q.wdata, 1'b1);
                                end
                                else
                                begin
                                    state_nxt = S_RSTART;
                                    cmd_nxt   = mk_cmd(OP_START, 8'h00, 1'b1);
                                end
                            S_RSTART:
                            begin
                                state_nxt = S_CTRL_R;
                                cmd_nxt   = mk_cmd(OP_WRITE, ctrl_r, 1'b1);
                            end
                            S_CTRL_R:
                            begin
                                state_nxt = S_READ;
                                cmd_nxt   = mk_cmd(OP_READ, 8'hff, 1'b1);   // single byte with no ack
                            end
                            default:
                            begin
                                rd_cap    = (state == S_READ);
                                state_nxt = S_STOP;
                                cmd_nxt   = mk_cmd(OP_STOP, 8'h00, 1'b1);
                            end
                        endcase
                    end
                end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            cmd_valid <= 1'b0;
            done      <= 1'b0;
            nack_q    <= 1'b0;
        end
        else
        begin
            state     <= state_nxt;
            cmd_valid <= issue;
            done      <= fin;
            if (req_valid)
                nack_q <= 1'b0;
            else if (nack_set)
                nack_q <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (req_valid)
            req_q <= req;
        if (rd_cap)
            rdata_q <= bus_rsp.data;
        cmd <= cmd_nxt;
    end

endmodule

// ==== i2c_bit_engine.sv ====
`timescale 1ns/1ps
module i2c_bit_engine #(
    parameter int CLK_DIV = 4
) (
    input  logic                 CLK,
    input  logic                 RESET,
    input  eeprom_pkg::i2c_cmd_t cmd,
    input  logic                 cmd_valid,
    input  logic                 sda_in,
    output logic                 cmd_done,
    output eeprom_pkg::i2c_rsp_t rsp,
    output logic                 scl,
    output logic                 sda_drive_low
);
    import eeprom_pkg::*;

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic             active;
    i2c_op_e          op;
    logic             ack_lvl;
    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       phase;
    logic [3:0]       bit_cnt;
    logic [7:0]       shreg;
    logic             samp;
    logic             quarter_end;
    logic             bit_end;
    logic             last_bit;
    logic             scl_nxt;
    logic             sda_nxt;

    assign quarter_end = (div_cnt == DIV_W'(CLK_DIV - 1));
    assign bit_end     = active && quarter_end && (phase == 2'd3);
    // byte ops run 8 data bits plus ack
    assign last_bit    = (op == OP_WRITE || op == OP_READ) ? (bit_cnt == 4'd8) : 1'b1;
    assign cmd_done    = bit_end && last_bit;
    assign rsp         = '{data: shreg, ack: samp};

    // pin levels per quarter, scl high in quarters 1 and 2
    always_comb
    begin
        scl_nxt = (phase == 2'd1) || (phase == 2'd2);
        sda_nxt = 1'b0;
        case (op)
            OP_START: sda_nxt = phase[1];   // sda falls while scl high
            OP_STOP:
            begin
                scl_nxt = (phase != 2'd0);
                sda_nxt = !phase[1];        // sda released while scl high
            end
            OP_WRITE: sda_nxt = (bit_cnt != 4'd8) && !shreg[7];
            OP_READ:  sda_nxt = (bit_cnt == 4'd8) && !ack_lvl;
            default:  sda_nxt = 1'b0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active        <= 1'b0;
            div_cnt       <= '0;
            phase         <= 2'd0;
            bit_cnt       <= 4'd0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
        end
        else if (!active)
        begin
            if (cmd_valid)
            begin
                active  <= 1'b1;
                div_cnt <= '0;
                phase   <= 2'd0;
                bit_cnt <= 4'd0;
            end
        end
        else
        begin
            scl           <= scl_nxt;   // pins hold their last level when idle
            sda_drive_low <= sda_nxt;
            if (quarter_end)
            begin
                div_cnt <= '0;
                phase   <= phase + 2'd1;
            end
            else
                div_cnt <= div_cnt + 1'b1;
            if (bit_end)
            begin
                bit_cnt <= bit_cnt + 4'd1;
                if (last_bit)
                    active <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!active && cmd_valid)
        begin
            op      <= cmd.op;
            ack_lvl <= cmd.ack;
            shreg   <= cmd.data;
        end
        else if (active)
        begin
            if (quarter_end && phase == 2'd1)
                samp <= sda_in;   // middle of scl high
            if (bit_end && bit_cnt < 4'd8)
                shreg <= {shreg[6:0], samp};   // msb out, sampled bit in
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f compile.f --top-module tb_eeprom_ctrl \
    -o sim_eeprom &&
./obj_dir/sim_eeprom | tee /dev/stderr | grep -q "^all tests passed$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== tb_eeprom_ctrl.sv ====
`timescale 1ns/1ps
module tb_eeprom_ctrl;
    import eeprom_pkg::*;

    typedef enum {T_RESET, T_WRITE, T_READ, T_BUSY} test_op_e;

    typedef struct {
        string       name;
        test_op_e    op;
        logic [10:0] addr;
        int          data;       // negative means random
        logic        en;
        logic        exp_nack;
    } test_t;

    logic       CLK;
    logic       RESET;
    logic [1:0] wb_adr;
    logic [7:0] wb_dat_i;
    logic [7:0] wb_dat_o;
    logic       wb_we;
    logic       wb_stb;
    logic       wb_cyc;
    logic       wb_ack;
    logic       scl;
    logic       dut_sda_low;
    logic       model_sda_low;
    logic       sda;
    logic       model_en;

    logic [7:0] shadow [0:2047];
    test_t      tests[$];
    int         errors;
    int         checks;
    int         test_err;
    int         n_pass;
    int         n_fail;
    int         cycles;
    int         limit;

    assign sda = !(dut_sda_low || model_sda_low);   // open drain bus

    eeprom_ctrl_top #(.CLK_DIV(4)) i_dut (
        .CLK(CLK), .RESET(RESET),
        .wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_we(wb_we),
        .wb_stb(wb_stb), .wb_cyc(wb_cyc), .wb_ack(wb_ack),
        .scl(scl), .sda_drive_low(dut_sda_low), .sda_in(sda)
    );

    tb_eeprom_model i_model (
        .scl(scl), .sda(sda), .enable(model_en), .sda_drive_low(model_sda_low)
    );

    initial
    begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        cycles++;
        if (cycles > limit)
        begin
            $display("timeout after %0d cycles, a transaction never finished", cycles);
            $display("tests failed");
            $finish;
        end
    end

    task automatic add_test(string name, test_op_e op, logic [10:0] addr, int data,
                            logic en, logic exp_nack);
        test_t t;
        t.name     = name;
        t.op       = op;
        t.addr     = addr;
        t.data     = data;
        t.en       = en;
        t.exp_nack = exp_nack;
        tests.push_back(t);
    endtask

    task automatic wb_write(logic [1:0] adr, logic [7:0] dat);
        @(posedge CLK);
        #1;
        wb_adr   = adr;
        wb_dat_i = dat;
        wb_we    = 1'b1;
        wb_stb   = 1'b1;
        wb_cyc   = 1'b1;
        do
        begin
            @(posedge CLK);
            #1;
        end while (!wb_ack);
        wb_stb = 1'b0;
        wb_cyc = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(logic [1:0] adr, output logic [7:0] dat);
        @(posedge CLK);
        #1;
        wb_adr = adr;
        wb_we  = 1'b0;
        wb_stb = 1'b1;
        wb_cyc = 1'b1;
        do
        begin
            @(posedge CLK);
            #1;
        end while (!wb_ack);
        dat    = wb_dat_o;
        wb_stb = 1'b0;
        wb_cyc = 1'b0;
    endtask

    // poll until idle with done seen at least once
    task automatic wait_done(output logic [7:0] st, output int n_done);
        n_done = 0;
        do
        begin
            wb_read(REG_CTRL, st);
            if (st[CTRL_DONE])
                n_done++;
        end while (st[CTRL_BUSY] || n_done == 0);
    endtask

    task automatic compare_byte(string tname, string what, logic [7:0] exp, logic [7:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            $display("FAILED %s %s expected %02h actual %02h", tname, what, exp, act);
            errors++;
            test_err++;
        end
    endtask

    task automatic start_req(logic [10:0] addr, logic [7:0] data, logic wr);
        wb_write(REG_ADDR_LO, addr[7:0]);
        wb_write(REG_ADDR_HI, {5'b0, addr[10:8]});
        if (wr)
            wb_write(REG_DATA, data);
        wb_write(REG_CTRL, wr ? 8'h01 : 8'h02);
    endtask

    task automatic run_test(test_t t);
        logic [7:0] st;
        logic [7:0] got;
        logic [7:0] d;
        logic [7:0] exp_st;
        int         n_done;
        d        = (t.data < 0) ? 8'($urandom) : 8'(t.data);
        exp_st   = {5'b0, t.exp_nack, 1'b1, 1'b0};   // nack and done set, busy clear
        model_en = t.en;
        case (t.op)
            T_RESET:
            begin
                compare_byte(t.name, "scl", 8'h01, {7'b0, scl});
                compare_byte(t.name, "sda_drive_low", 8'h00, {7'b0, dut_sda_low});
                wb_read(REG_CTRL, got);
                compare_byte(t.name, "ctrl", 8'h00, got);
                wb_read(REG_ADDR_LO, got);
                compare_byte(t.name, "addr_lo", 8'h00, got);
                wb_read(REG_ADDR_HI, got);
                compare_byte(t.name, "addr_hi", 8'h00, got);
                wb_read(REG_DATA, got);
                compare_byte(t.name, "data", 8'h00, got);
            end
            T_WRITE:
            begin
                start_req(t.addr, d, 1'b1);
                wait_done(st, n_done);
                compare_byte(t.name, "status", exp_st, st);
                if (!t.exp_nack)
                    shadow[t.addr] = d;
            end
            T_READ:
            begin
                start_req(t.addr, 8'h00, 1'b0);
                wait_done(st, n_done);
                compare_byte(t.name, "status", exp_st, st);
                if (!t.exp_nack)
                begin
                    wb_read(REG_DATA, got);
                    compare_byte(t.name, "data", shadow[t.addr], got);
                end
            end
            default:
            begin
                start_req(t.addr, d, 1'b1);
                wb_read(REG_CTRL, st);
                compare_byte(t.name, "busy", 8'h01, {7'b0, st[CTRL_BUSY]});
                // second request aimed at the neighbor gets dropped
                wb_write(REG_ADDR_LO, t.addr[7:0] + 8'd1);
                wb_write(REG_DATA, ~d);
                wb_write(REG_CTRL, 8'h01);
                wait_done(st, n_done);
                compare_byte(t.name, "done count", 8'd1, 8'(n_done));
                compare_byte(t.name, "status", exp_st, st);
                shadow[t.addr] = d;
                wb_read(REG_CTRL, got);
                compare_byte(t.name, "done cleared", 8'h00, {7'b0, got[CTRL_DONE]});
            end
        endcase
    endtask

    initial
    begin
        void'($urandom(32'hbb7af0ed));
        RESET    = 1'b1;
        wb_adr   = 2'd0;
        wb_dat_i = 8'h00;
        wb_we    = 1'b0;
        wb_stb   = 1'b0;
        wb_cyc   = 1'b0;
        model_en = 1'b1;
        errors   = 0;
        checks   = 0;
        n_pass   = 0;
        n_fail   = 0;
        cycles   = 0;
        limit    = 1000000;
        for (int a = 0; a < 2048; a++)
            shadow[a[10:0]] = a[7:0] ^ {a[10:8], a[10:8], a[10:9]} ^ 8'h5a;

        add_test("reset",      T_RESET, 11'h000, 0,     1'b1, 1'b0);
        add_test("wr_blk0",    T_WRITE, 11'h00a, 8'h3c, 1'b1, 1'b0);
        add_test("wr_blk1",    T_WRITE, 11'h135, 8'ha1, 1'b1, 1'b0);
        add_test("wr_blk2",    T_WRITE, 11'h2c0, 8'h00, 1'b1, 1'b0);
        add_test("wr_blk3",    T_WRITE, 11'h3ff, 8'hff, 1'b1, 1'b0);
        add_test("wr_blk4",    T_WRITE, 11'h401, 8'h5e, 1'b1, 1'b0);
        add_test("wr_blk5",    T_WRITE, 11'h57e, 8'h81, 1'b1, 1'b0);
        add_test("wr_blk6",    T_WRITE, 11'h6a5, 8'h7e, 1'b1, 1'b0);
        add_test("wr_blk7",    T_WRITE, 11'h7f0, 8'hc3, 1'b1, 1'b0);
        add_test("rd_blk0",    T_READ,  11'h00a, 0,     1'b1, 1'b0);
        add_test("rd_blk1",    T_READ,  11'h135, 0,     1'b1, 1'b0);
        add_test("rd_blk2",    T_READ,  11'h2c0, 0,     1'b1, 1'b0);
        add_test("rd_blk3",    T_READ,  11'h3ff, 0,     1'b1, 1'b0);
        add_test("rd_blk4",    T_READ,  11'h401, 0,     1'b1, 1'b0);
        add_test("rd_blk5",    T_READ,  11'h57e, 0,     1'b1, 1'b0);
        add_test("rd_blk6",    T_READ,  11'h6a5, 0,     1'b1, 1'b0);
        add_test("rd_blk7",    T_READ,  11'h7f0, 0,     1'b1, 1'b0);
        add_test("ovr_wr",     T_WRITE, 11'h135, -1,    1'b1, 1'b0);
        add_test("ovr_rd",     T_READ,  11'h135, 0,     1'b1, 1'b0);
        add_test("ovr_nbr",    T_READ,  11'h136, 0,     1'b1, 1'b0);
        add_test("nack_wr",    T_WRITE, 11'h2c0, 8'h77, 1'b0, 1'b1);
        add_test("nack_rd",    T_READ,  11'h3ff, 0,     1'b0, 1'b1);
        add_test("nack_check", T_READ,  11'h2c0, 0,     1'b1, 1'b0);
        add_test("busy_start", T_BUSY,  11'h401, -1,    1'b1, 1'b0);
        add_test("busy_rd",    T_READ,  11'h401, 0,     1'b1, 1'b0);
        add_test("busy_nbr",   T_READ,  11'h402, 0,     1'b1, 1'b0);

        // twice 41 bit periods of 16 clocks per test
        limit = 2 * tests.size() * 41 * 16 + 10;

        repeat (10) @(posedge CLK);
        #1;
        RESET = 1'b0;

        foreach (tests[i])
        begin
            test_err = 0;
            run_test(tests[i]);
            if (test_err == 0)
            begin
                n_pass++;
                $display("ok      %s", tests[i].name);
            end
            else
            begin
                n_fail++;
                $display("failed  %s (%0d errors)", tests[i].name, test_err);
            end
        end

        $display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
                 tests.size(), n_pass, n_fail, checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== tb_eeprom_model.sv ====
`timescale 1ns/1ps
module tb_eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic enable,
    output logic sda_drive_low
);
    typedef enum {M_IDLE, M_DEV, M_ADDR, M_WDATA, M_RDATA, M_WAIT} mstate_e;

    logic [7:0]  mem [0:2047];
    mstate_e     state;
    mstate_e     nstate;
    int          cnt;
    logic        ack_slot;
    logic        drv;
    logic [7:0]  shreg;
    logic [7:0]  rbyte;
    logic [10:0] ptr;
    logic        scl_q;
    logic        sda_q;

    function automatic logic [7:0] fill(logic [10:0] a);
        return a[7:0] ^ {a[10:8], a[10:8], a[10:9]} ^ 8'h5a;
    endfunction

    assign sda_drive_low = drv && enable;

    initial
    begin
        for (int a = 0; a < 2048; a++)
            mem[a[10:0]] = fill(a[10:0]);
        state    = M_IDLE;
        nstate   = M_IDLE;
        cnt      = 0;
        ack_slot = 1'b0;
        drv      = 1'b0;
        ptr      = 11'd0;
    end

    always @(scl, sda)
    begin
        if (scl === scl_q)
        begin
            // sda moved while scl steady
            if (scl === 1'b1 && sda_q === 1'b1 && sda === 1'b0 && enable)
            begin
                state    = M_DEV;   // start or repeated start
                cnt      = 0;
                ack_slot = 1'b0;
                drv      = 1'b0;
            end
            else if (scl === 1'b1 && sda_q === 1'b0 && sda === 1'b1)
            begin
                state = M_IDLE;     // stop
                drv   = 1'b0;
            end
        end
        else if (scl === 1'b1)
        begin
            if (state == M_RDATA)
                cnt++;
            else if ((state == M_DEV || state == M_ADDR || state == M_WDATA) && cnt < 8)
            begin
                shreg = {shreg[6:0], sda};
                cnt++;
            end
        end
        else if (scl === 1'b0)
        begin
            if (state == M_DEV || state == M_ADDR || state == M_WDATA)
            begin
                if (ack_slot)
                begin
                    ack_slot = 1'b0;
                    drv      = 1'b0;
                    cnt      = 0;
                    state    = nstate;
                    if (nstate == M_RDATA)
                    begin
                        rbyte = mem[ptr];
                        ptr   = ptr + 11'd1;
                        drv   = !rbyte[7];
                    end
                end
                else if (cnt == 8)
                begin
                    ack_slot = 1'b1;
                    drv      = 1'b1;
                    if (state == M_DEV)
                    begin
                        if (shreg[7:4] == 4'b1010)
                        begin
                            ptr[10:8] = shreg[3:1];
                            nstate    = shreg[0] ? M_RDATA : M_ADDR;
                        end
                        else
                        begin
                            ack_slot = 1'b0;   // not our device
                            drv      = 1'b0;
                            state    = M_WAIT;
                        end
                    end
                    else if (state == M_ADDR)
                    begin
                        ptr[7:0] = shreg;
                        nstate   = M_WDATA;
                    end
                    else
                    begin
                        mem[ptr] = shreg;
                        ptr      = ptr + 11'd1;
                        nstate   = M_WDATA;
                    end
                end
            end
            else if (state == M_RDATA)
            begin
                if (cnt == 8)
                begin
                    drv   = 1'b0;   // master acks or not, we are done
                    state = M_WAIT;
                end
                else
                    drv = !rbyte[7-cnt];
            end
            else
                drv = 1'b0;
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

// ==== wb_eeprom_regs.sv ====
`timescale 1ns/1ps
module wb_eeprom_regs (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic [1:0]              wb_adr,
    input  logic [7:0]              wb_dat_i,
    input  logic                    wb_we,
    input  logic                    wb_stb,
    input  logic                    wb_cyc,
    input  logic                    busy,
    input  logic                    done,
    input  eeprom_pkg::eeprom_rsp_t rsp,
    output logic [7:0]              wb_dat_o,
    output logic                    wb_ack,
    output eeprom_pkg::eeprom_req_t req,
    output logic                    req_valid
);
    import eeprom_pkg::*;

    logic              access;
    logic              wr_access;
    logic              rd_access;
    logic              launch;
    logic [ADDR_W-1:0] addr_q;
    logic [7:0]        data_q;
    logic              wr_q;
    logic              done_q;
    logic              nack_q;
    logic [7:0]        rd_mux;

    // one access per stb, ack in the following cycle
    assign access    = wb_stb && wb_cyc && !wb_ack;
    assign wr_access = access && wb_we;
    assign rd_access = access && !wb_we;
    assign launch    = wr_access && (wb_adr == REG_CTRL) && !busy &&
                       (wb_dat_i[CTRL_START_WR] || wb_dat_i[CTRL_START_RD]);

    assign req = '{wr: wr_q, addr: addr_q, wdata: data_q};

    always_comb
    begin
        rd_mux = 8'h00;
        case (wb_adr)
            REG_ADDR_LO: rd_mux = addr_q[7:0];
            REG_ADDR_HI: rd_mux = {{(16 - ADDR_W){1'b0}}, addr_q[ADDR_W-1:8]};
            REG_DATA:    rd_mux = data_q;
            default:
            begin
                rd_mux[CTRL_BUSY] = busy;
                rd_mux[CTRL_DONE] = done_q;
                rd_mux[CTRL_NACK] = nack_q;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wb_ack    <= 1'b0;
            req_valid <= 1'b0;
            addr_q    <= '0;
            data_q    <= 8'h00;
            done_q    <= 1'b0;
            nack_q    <= 1'b0;
        end
        else
        begin
            wb_ack    <= access;
            req_valid <= launch;
            if (wr_access && wb_adr == REG_ADDR_LO)
                addr_q[7:0] <= wb_dat_i;
            if (wr_access && wb_adr == REG_ADDR_HI)
                addr_q[ADDR_W-1:8] <= wb_dat_i[ADDR_W-9:0];
            if (wr_access && wb_adr == REG_DATA)
                data_q <= wb_dat_i;
            else if (done && !wr_q && !rsp.nack)
                data_q <= rsp.rdata;   // last read byte
            if (launch)
            begin
                done_q <= 1'b0;
                nack_q <= 1'b0;
            end
            else if (done)
            begin
                done_q <= 1'b1;
                nack_q <= rsp.nack;
            end
            else if (rd_access && wb_adr == REG_CTRL)
                done_q <= 1'b0;   // cleared by status read
        end
    end

    always_ff @(posedge CLK)
    begin
        if (launch)
            wr_q <= wb_dat_i[CTRL_START_WR];   // write wins if both bits set
        if (rd_access)
            wb_dat_o <= rd_mux;
    end

endmodule
